// ==== verilog/gamePkg.sv ====
`default_nettype none

package gamePkg;

    // Screen coordinates and widths
    localparam int COORD_W = 9;
    localparam int HEALTH_W = 7;
    localparam int SCORE_W = 8;

    // Signed box edges need room for -ATTACK_LONG and 511 + ATTACK_LONG
    localparam int BOX_W = COORD_W + 2;
    typedef logic signed [BOX_W-1:0] boxCoord;

    // Attack and enemy box sizes in pixels
    localparam int ATTACK_SHORT = 16;
    localparam int ATTACK_LONG = 80;
    localparam int ENEMY_W = 26;
    localparam int ENEMY_H = 26;

    // Enemy health
    localparam logic [HEALTH_W-1:0] MAX_HEALTH = 7'd100;
    localparam logic [HEALTH_W-1:0] DAMAGE = 7'd25;

    // Respawn timing, counted in divided frame ticks
    localparam int FRAME_DIV = 4;
    localparam int FRAME_CNT_W = $clog2(FRAME_DIV);
    localparam int RESPAWN_TICKS = 8;
    localparam int RESP_CNT_W = $clog2(RESPAWN_TICKS);

    typedef enum logic [1:0] {
        dirDown = 2'd0,
        dirLeft = 2'd1,
        dirUp = 2'd2,
        dirRight = 2'd3
    } faceDir;

    typedef enum logic {
        stAlive = 1'b0,
        stRespawn = 1'b1
    } enemyState;

endpackage

`default_nettype wire

// ==== verilog/frameTick.sv ====
`timescale 1ns/100ps
`default_nettype none

module frameTick (
    input  logic Clk,
    input  logic rstN,
    input  logic frameSync,
    output logic respawnTick
);

    logic syncMeta;
    logic syncOut;
    logic frameDly;
    logic frameRise;
    logic [gamePkg::FRAME_CNT_W-1:0] edgeCnt;

    // Two flops against metastability, then a delayed copy for the edge
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            syncMeta <= 1'b0;
            syncOut <= 1'b0;
            frameDly <= 1'b0;
        end else begin
            syncMeta <= frameSync;
            syncOut <= syncMeta;
            frameDly <= syncOut;
        end
    end

    assign frameRise = syncOut & ~frameDly;

    // Divide frame edges down to the slow respawn tick
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            edgeCnt <= '0;
            respawnTick <= 1'b0;
        end else begin
            respawnTick <= 1'b0;
            if (frameRise) begin
                if (edgeCnt == gamePkg::FRAME_CNT_W'(gamePkg::FRAME_DIV - 1)) begin
                    edgeCnt <= '0;
                    respawnTick <= 1'b1;
                end else begin
                    edgeCnt <= edgeCnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hitDetect.sv ====
`timescale 1ns/100ps
`default_nettype none

module hitDetect (
    input  logic                         Clk,
    input  logic                         rstN,
    input  logic                         atkValid,
    input  logic                         atkReady,
    input  gamePkg::faceDir              atkDir,
    input  logic [gamePkg::COORD_W-1:0]  atkX,
    input  logic [gamePkg::COORD_W-1:0]  atkY,
    input  logic [gamePkg::COORD_W-1:0]  enemyX,
    input  logic [gamePkg::COORD_W-1:0]  enemyY,
    output logic                         hitValid,
    output logic                         hit
);

    logic accept;
    gamePkg::boxCoord ax;
    gamePkg::boxCoord ay;
    gamePkg::boxCoord boxLeft;
    gamePkg::boxCoord boxRight;
    gamePkg::boxCoord boxTop;
    gamePkg::boxCoord boxBottom;

    // Stage one registers
    logic s1Valid;
    gamePkg::boxCoord atkLeft;
    gamePkg::boxCoord atkRight;
    gamePkg::boxCoord atkTop;
    gamePkg::boxCoord atkBottom;
    gamePkg::boxCoord enLeft;
    gamePkg::boxCoord enRight;
    gamePkg::boxCoord enTop;
    gamePkg::boxCoord enBottom;

    assign accept = atkValid & atkReady;

    // Zero extend, then work in signed so left and up never wrap
    assign ax = gamePkg::boxCoord'(atkX);
    assign ay = gamePkg::boxCoord'(atkY);

    always_comb begin
        boxLeft = ax;
        boxRight = ax + gamePkg::boxCoord'(gamePkg::ATTACK_SHORT);
        boxTop = ay;
        boxBottom = ay + gamePkg::boxCoord'(gamePkg::ATTACK_LONG);
        case (atkDir)
            gamePkg::dirUp: begin
                boxTop = ay - gamePkg::boxCoord'(gamePkg::ATTACK_LONG);
                boxBottom = ay;
            end
            gamePkg::dirLeft: begin
                boxLeft = ax - gamePkg::boxCoord'(gamePkg::ATTACK_LONG);
                boxRight = ax;
                boxBottom = ay + gamePkg::boxCoord'(gamePkg::ATTACK_SHORT);
            end
            gamePkg::dirRight: begin
                boxRight = ax + gamePkg::boxCoord'(gamePkg::ATTACK_LONG);
                boxBottom = ay + gamePkg::boxCoord'(gamePkg::ATTACK_SHORT);
            end
            default: ;  // dirDown keeps the defaults above
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            hitValid <= 1'b0;
        end else begin
            s1Valid <= accept;
            hitValid <= s1Valid;
        end
    end

    // Box edges, sampled together with the request
    always_ff @(posedge Clk) begin
        atkLeft <= boxLeft;
        atkRight <= boxRight;
        atkTop <= boxTop;
        atkBottom <= boxBottom;
        enLeft <= gamePkg::boxCoord'(enemyX);
        enRight <= gamePkg::boxCoord'(enemyX) + gamePkg::boxCoord'(gamePkg::ENEMY_W);
        enTop <= gamePkg::boxCoord'(enemyY);
        enBottom <= gamePkg::boxCoord'(enemyY) + gamePkg::boxCoord'(gamePkg::ENEMY_H);
    end

    // Inclusive overlap on both axes
    always_ff @(posedge Clk) begin
        hit <= (atkLeft <= enRight) && (enLeft <= atkRight) &&
               (atkTop <= enBottom) && (enTop <= atkBottom);
    end

endmodule

`default_nettype wire

// ==== verilog/combatState.sv ====
`timescale 1ns/100ps
`default_nettype none

module combatState (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          hitValid,
    input  logic                          hit,
    input  logic                          respawnTick,
    output logic                          enemyAlive,
    output logic [gamePkg::HEALTH_W-1:0]  enemyHealth,
    output logic [gamePkg::SCORE_W-1:0]   score
);

    gamePkg::enemyState state;
    gamePkg::enemyState stateNext;
    logic [gamePkg::HEALTH_W-1:0] healthNext;
    logic [gamePkg::SCORE_W-1:0] scoreNext;
    logic [gamePkg::RESP_CNT_W-1:0] respawnCnt;
    logic [gamePkg::RESP_CNT_W-1:0] respawnCntNext;

    assign enemyAlive = (state == gamePkg::stAlive);

    always_comb begin
        stateNext = state;
        healthNext = enemyHealth;
        scoreNext = score;
        respawnCntNext = respawnCnt;
        case (state)
            gamePkg::stAlive: begin
                if (hitValid && hit) begin
                    scoreNext = score + 1'b1;
                    // Saturate at zero, the killing blow sends us to respawn
                    if (enemyHealth <= gamePkg::DAMAGE) begin
                        healthNext = '0;
                        stateNext = gamePkg::stRespawn;
                    end else begin
                        healthNext = enemyHealth - gamePkg::DAMAGE;
                    end
                end
            end
            gamePkg::stRespawn: begin
                // Late hits from the pipeline are dropped here
                if (respawnTick) begin
                    if (respawnCnt ==
                        gamePkg::RESP_CNT_W'(gamePkg::RESPAWN_TICKS - 1)) begin
                        respawnCntNext = '0;
                        healthNext = gamePkg::MAX_HEALTH;
                        stateNext = gamePkg::stAlive;
                    end else begin
                        respawnCntNext = respawnCnt + 1'b1;
                    end
                end
            end
            default: stateNext = gamePkg::stAlive;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= gamePkg::stAlive;
            enemyHealth <= gamePkg::MAX_HEALTH;
            score <= '0;
            respawnCnt <= '0;
        end else begin
            state <= stateNext;
            enemyHealth <= healthNext;
            score <= scoreNext;
            respawnCnt <= respawnCntNext;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/combatTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module combatTop (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          frameSync,
    input  logic                          atkValid,
    input  gamePkg::faceDir               atkDir,
    input  logic [gamePkg::COORD_W-1:0]   atkX,
    input  logic [gamePkg::COORD_W-1:0]   atkY,
    input  logic [gamePkg::COORD_W-1:0]   enemyX,
    input  logic [gamePkg::COORD_W-1:0]   enemyY,
    output logic                          atkReady,
    output logic                          enemyAlive,
    output logic [gamePkg::HEALTH_W-1:0]  enemyHealth,
    output logic [gamePkg::SCORE_W-1:0]   score
);

    logic hitValid;
    logic hit;
    logic respawnTick;

    // Attacks stall while the enemy is down
    assign atkReady = enemyAlive;

    frameTick uFrameTick (
        .Clk         (Clk),
        .rstN        (rstN),
        .frameSync   (frameSync),
        .respawnTick (respawnTick)
    );

    hitDetect uHitDetect (
        .Clk      (Clk),
        .rstN     (rstN),
        .atkValid (atkValid),
        .atkReady (enemyAlive),
        .atkDir   (atkDir),
        .atkX     (atkX),
        .atkY     (atkY),
        .enemyX   (enemyX),
        .enemyY   (enemyY),
        .hitValid (hitValid),
        .hit      (hit)
    );

    combatState uCombatState (
        .Clk         (Clk),
        .rstN        (rstN),
        .hitValid    (hitValid),
        .hit         (hit),
        .respawnTick (respawnTick),
        .enemyAlive  (enemyAlive),
        .enemyHealth (enemyHealth),
        .score       (score)
    );

endmodule

`default_nettype wire

// ==== verification/combatSva.sv ====
`timescale 1ns/100ps
`default_nettype none

module combatSva (
    input logic                         Clk,
    input logic                         rstN,
    input logic                         atkValid,
    input logic                         atkReady,
    input logic                         hitValid,
    input logic                         enemyAlive,
    input logic [gamePkg::HEALTH_W-1:0] enemyHealth,
    input logic [gamePkg::SCORE_W-1:0]  score
);

    // Accepted request reaches the state block two edges later
    assert property (@(posedge Clk) disable iff (!rstN)
        hitValid == $past(atkValid && atkReady, 2))
        else $error("hitValid does not follow an accepted request by two cycles");

    assert property (@(posedge Clk) disable iff (!rstN)
        enemyAlive == (enemyHealth != '0))
        else $error("enemyAlive disagrees with enemyHealth");

    // Score only moves on the edge that consumes a hit
    assert property (@(posedge Clk) disable iff (!rstN)
        (score != $past(score)) |-> $past(hitValid))
        else $error("score changed without a valid hit");

    assert property (@(posedge Clk) disable iff (!rstN)
        enemyHealth <= gamePkg::MAX_HEALTH)
        else $error("enemyHealth above full health");

endmodule

bind combatTop combatSva uSva (
    .Clk         (Clk),
    .rstN        (rstN),
    .atkValid    (atkValid),
    .atkReady    (atkReady),
    .hitValid    (hitValid),
    .enemyAlive  (enemyAlive),
    .enemyHealth (enemyHealth),
    .score       (score)
);

`default_nettype wire

// ==== verification/combatTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module combatTb;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_REQ = 200;
    localparam int FRAME_HALF = 12;
    // A frame edge may still sit in the synchronizer at the killing blow
    localparam int RESP_MIN = gamePkg::FRAME_DIV * (gamePkg::RESPAWN_TICKS - 1);
    localparam int RESP_MAX = gamePkg::FRAME_DIV * gamePkg::RESPAWN_TICKS;
    localparam int WATCHDOG_CYCLES = NUM_REQ * 40 +
                                     (NUM_REQ / 4 + 1) * RESP_MAX * 2 * FRAME_HALF;

    logic Clk;
    logic rstN;
    logic frameSync;
    logic atkValid;
    gamePkg::faceDir atkDir;
    logic [gamePkg::COORD_W-1:0] atkX;
    logic [gamePkg::COORD_W-1:0] atkY;
    logic [gamePkg::COORD_W-1:0] enemyX;
    logic [gamePkg::COORD_W-1:0] enemyY;
    logic atkReady;
    logic enemyAlive;
    logic [gamePkg::HEALTH_W-1:0] enemyHealth;
    logic [gamePkg::SCORE_W-1:0] score;

    logic [31:0] rngState;
    // Reference model of the enemy
    logic mAlive;
    logic [gamePkg::HEALTH_W-1:0] mHealth;
    logic [gamePkg::SCORE_W-1:0] mScore;
    logic [1:0] pipeValid;
    logic [1:0] pipeHit;
    int frameEdges = 0;
    int errors = 0;
    int checks = 0;
    int deaths = 0;
    int discarded = 0;

    combatTop uut (.*);

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // Inclusive overlap in plain integers so nothing wraps
    function automatic logic boxHit(gamePkg::faceDir dir, int ax, int ay, int ex, int ey);
        int xLo;
        int xHi;
        int yLo;
        int yHi;
        xLo = (dir == gamePkg::dirLeft) ? ax - gamePkg::ATTACK_LONG : ax;
        xHi = (dir == gamePkg::dirLeft) ? ax : ax + ((dir == gamePkg::dirRight) ?
              gamePkg::ATTACK_LONG : gamePkg::ATTACK_SHORT);
        yLo = (dir == gamePkg::dirUp) ? ay - gamePkg::ATTACK_LONG : ay;
        yHi = (dir == gamePkg::dirUp) ? ay : ay + ((dir == gamePkg::dirDown) ?
              gamePkg::ATTACK_LONG : gamePkg::ATTACK_SHORT);
        return (xLo <= ex + gamePkg::ENEMY_W) && (ex <= xHi) &&
               (yLo <= ey + gamePkg::ENEMY_H) && (ey <= yHi);
    endfunction

    task automatic compareValue(string name, int expected, int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERROR %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // Offsets straddle every box edge so roughly half of them hit
    task automatic launchRequest();
        gamePkg::faceDir dir;
        logic [31:0] r;
        int ex;
        int ey;
        int longOff;
        int shortOff;
        r = nextRand();
        dir = gamePkg::faceDir'(r[1:0]);
        ex = 120 + int'(nextRand() % 32'd250);
        ey = 120 + int'(nextRand() % 32'd250);
        longOff = int'(nextRand() % 32'd146) - 100;
        shortOff = int'(nextRand() % 32'd71) - 30;
        // Up and left reach back from the origin
        if (dir == gamePkg::dirUp || dir == gamePkg::dirLeft) begin
            longOff = gamePkg::ENEMY_W - longOff;
        end
        atkValid <= 1'b1;
        atkDir <= dir;
        enemyX <= gamePkg::COORD_W'(ex);
        enemyY <= gamePkg::COORD_W'(ey);
        if (dir == gamePkg::dirLeft || dir == gamePkg::dirRight) begin
            atkX <= gamePkg::COORD_W'(ex + longOff);
            atkY <= gamePkg::COORD_W'(ey + shortOff);
        end else begin
            atkX <= gamePkg::COORD_W'(ex + shortOff);
            atkY <= gamePkg::COORD_W'(ey + longOff);
        end
    endtask

    initial begin
        Clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) Clk = ~Clk;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the run finished", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        int cycle;
        int accepted;
        int drain;
        logic applyValid;
        logic applyHit;
        cycle = 0;
        accepted = 0;
        drain = 0;
        rngState = 32'h3255;
        rstN <= 1'b0;
        frameSync <= 1'b0;
        atkValid <= 1'b0;
        atkDir <= gamePkg::dirDown;
        atkX <= '0;
        atkY <= '0;
        enemyX <= '0;
        enemyY <= '0;
        mAlive = 1'b1;
        mHealth = gamePkg::MAX_HEALTH;
        mScore = '0;
        pipeValid = '0;
        pipeHit = '0;
        repeat (5) @(posedge Clk);
        rstN <= 1'b1;
        // First pass compares the reset values
        while (accepted < NUM_REQ || drain < 4) begin
            @(posedge Clk);
            if (!mAlive && enemyAlive) begin
                if (frameEdges < RESP_MIN || frameEdges > RESP_MAX) begin
                    errors++;
                    $display("Respawn came after %0d frame edges, outside %0d to %0d",
                             frameEdges, RESP_MIN, RESP_MAX);
                end
                mAlive = 1'b1;
                mHealth = gamePkg::MAX_HEALTH;
            end
            compareValue("enemyHealth", int'(mHealth), int'(enemyHealth));
            compareValue("score", int'(mScore), int'(score));
            compareValue("enemyAlive", int'(mAlive), int'(enemyAlive));
            compareValue("atkReady", int'(mAlive), int'(atkReady));
            // Accepted now and applied two edges later
            applyValid = pipeValid[1];
            applyHit = pipeHit[1];
            pipeValid = {pipeValid[0], atkValid & mAlive};
            pipeHit = {pipeHit[0],
                       boxHit(atkDir, int'(atkX), int'(atkY), int'(enemyX), int'(enemyY))};
            if (applyValid && applyHit && !mAlive) begin
                discarded++;
            end else if (applyValid && applyHit) begin
                mScore = mScore + gamePkg::SCORE_W'(1);
                if (mHealth <= gamePkg::DAMAGE) begin
                    mHealth = '0;
                    mAlive = 1'b0;
                    frameEdges = 0;
                    deaths++;
                end else begin
                    mHealth = mHealth - gamePkg::DAMAGE;
                end
            end
            if (pipeValid[0]) begin
                accepted++;
            end
            // A stalled request stays on the bus unchanged
            if (accepted >= NUM_REQ) begin
                atkValid <= 1'b0;
                drain++;
            end else if (pipeValid[0] || !atkValid) begin
                if (nextRand() % 32'd8 == 32'd0) begin
                    atkValid <= 1'b0;
                end else begin
                    launchRequest();
                end
            end
            cycle++;
            if (cycle % FRAME_HALF == 0) begin
                if (!frameSync && !mAlive) begin
                    frameEdges++;
                    if (frameEdges == RESP_MAX + 1) begin
                        errors++;
                        $display("Enemy still dead after %0d frame edges", RESP_MAX);
                    end
                end
                frameSync <= ~frameSync;
            end
        end
        if (deaths == 0) begin
            errors++;
            $display("The enemy was never killed, death and respawn went unexercised");
        end
        if (discarded == 0) begin
            errors++;
            $display("No hit followed a killing blow, the discard of late hits went unexercised");
        end
        $display("checks %0d, errors %0d, deaths %0d, discarded hits %0d",
                 checks, errors, deaths, discarded);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/gamePkg.sv
verilog/frameTick.sv
verilog/hitDetect.sv
verilog/combatState.sv
verilog/combatTop.sv
verification/combatSva.sv
verification/combatTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= combatTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
